// ==== hw/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    // datapath widths
    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    // rv64 shifts use six bits of amount
    localparam int shamt_w    = 6;
    // sequential pc step
    localparam int inst_bytes = 4;

    typedef logic [xlen-1:0]       xlen_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // instruction class, replaces the old one-hot type vector
    typedef enum logic [3:0] {
        op_lui    = 4'd0,
        op_auipc  = 4'd1,
        op_jal    = 4'd2,
        op_jalr   = 4'd3,
        op_branch = 4'd4,
        op_load   = 4'd5,
        op_store  = 4'd6,
        op_imm    = 4'd7,
        op_reg    = 4'd8
    } op_class_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_e;

    // decode payload into execute
    typedef struct packed {
        xlen_t     pc;
        op_class_e op_class;
        logic [2:0] funct3;
        // inst[30], picks sub / sra
        logic      alt;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        // register file reads
        xlen_t     src_a;
        xlen_t     src_b;
        // already sign-extended by decode
        xlen_t     imm;
    } id_ex_t;

    // register write from a later stage
    typedef struct packed {
        logic      wen;
        reg_addr_t rd;
        xlen_t     data;
    } fwd_t;

    typedef struct packed {
        alu_op_e op;
        xlen_t   a;
        xlen_t   b;
    } alu_req_t;

    // execute result toward mem
    typedef struct packed {
        xlen_t      pc;
        op_class_e  op_class;
        logic [2:0] funct3;
        reg_addr_t  rd;
        xlen_t      alu_result;
        xlen_t      store_data;
    } ex_mem_t;

endpackage

`default_nettype wire

// ==== hw/exu_id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_id_ex_reg import exu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   valid_in,
    input  id_ex_t id_in,
    input  logic   advance,
    input  logic   flush,
    output logic   valid,
    output id_ex_t id_q
);

    // flush beats hold on the valid bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (advance) begin
            valid <= valid_in;
        end
    end

    // payload only moves on advance
    // contents are don't-care while valid is low
    always_ff @(posedge clk) begin
        if (advance) begin
            id_q <= id_in;
        end
    end

    // an x on valid would leak into the fetch redirect
    valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(valid)
    ) else $error("id/ex valid is unknown");

endmodule

`default_nettype wire

// ==== hw/exu_operand_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_operand_stage import exu_pkg::*; (
    input  id_ex_t   id_q,
    input  fwd_t     fwd_mem,
    input  fwd_t     fwd_wb,
    output alu_req_t req,
    output xlen_t    rs1_val,
    output xlen_t    rs2_val
);

    // pick the youngest in-flight write to this register
    function automatic xlen_t fwd_sel(input reg_addr_t rs, input xlen_t rf_val,
                                      input logic en, input fwd_t mem, input fwd_t wb);
        xlen_t val;
        val = rf_val;
        if (en && rs != '0) begin
            // mem is younger than wb
            if (mem.wen && mem.rd == rs) begin
                val = mem.data;
            end else if (wb.wen && wb.rd == rs) begin
                val = wb.data;
            end
        end
        return val;
    endfunction

    logic use_rs2;
    logic is_shift;

    // only these classes read rs2
    assign use_rs2 = (id_q.op_class == op_branch) || (id_q.op_class == op_store) ||
                     (id_q.op_class == op_reg);

    assign rs1_val = fwd_sel(id_q.rs1, id_q.src_a, 1'b1, fwd_mem, fwd_wb);
    assign rs2_val = fwd_sel(id_q.rs2, id_q.src_b, use_rs2, fwd_mem, fwd_wb);

    // funct3 001 / 101 are the shifts
    assign is_shift = (id_q.funct3[1:0] == 2'b01);

    always_comb begin
        req.op = alu_add;
        req.a  = rs1_val;
        req.b  = id_q.imm;
        case (id_q.op_class)
            op_lui: begin
                req.a = '0;
            end
            op_auipc: begin
                req.a = id_q.pc;
            end
            // link value pc + 4
            op_jal, op_jalr: begin
                req.a = id_q.pc;
                req.b = xlen_t'(inst_bytes);
            end
            // compare by subtraction for the resolve flags
            op_branch: begin
                req.op = alu_sub;
                req.b  = rs2_val;
            end
            op_imm, op_reg: begin
                if (id_q.op_class == op_reg) begin
                    req.b = rs2_val;
                end
                if (is_shift) begin
                    req.b = xlen_t'(req.b[shamt_w-1:0]);
                end
                case (id_q.funct3)
                    // addi has no sub form
                    3'b000:  req.op = (id_q.alt && id_q.op_class == op_reg) ? alu_sub : alu_add;
                    3'b001:  req.op = alu_sll;
                    3'b010:  req.op = alu_slt;
                    3'b011:  req.op = alu_sltu;
                    3'b100:  req.op = alu_xor;
                    3'b101:  req.op = id_q.alt ? alu_sra : alu_srl;
                    3'b110:  req.op = alu_or;
                    default: req.op = alu_and;
                endcase
            end
            // load / store address rs1 + imm
            default: begin
                req.op = alu_add;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_alu import exu_pkg::*; (
    input  alu_req_t req,
    output xlen_t    result
);

    logic [shamt_w-1:0] shamt;
    xlen_t              diff;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt = req.b[shamt_w-1:0];
    assign diff  = req.a - req.b;

    // compares from the sign bits, same trick as branch resolve
    assign lt_signed   = (req.a[xlen-1] ^ req.b[xlen-1]) ? req.a[xlen-1] : diff[xlen-1];
    assign lt_unsigned = (req.a[xlen-1] ^ req.b[xlen-1]) ? req.b[xlen-1] : diff[xlen-1];

    always_comb begin
        case (req.op)
            alu_add:  result = req.a + req.b;
            alu_sub:  result = diff;
            // 0 or 1 result
            alu_slt:  result = xlen_t'(lt_signed);
            alu_sltu: result = xlen_t'(lt_unsigned);
            alu_and:  result = req.a & req.b;
            alu_or:   result = req.a | req.b;
            alu_xor:  result = req.a ^ req.b;
            alu_sll:  result = req.a << shamt;
            alu_srl:  result = req.a >> shamt;
            // arithmetic shift keeps the sign
            alu_sra:  result = xlen_t'($signed(req.a) >>> shamt);
            default:  result = req.a + req.b;
        endcase
    end

    // decode falls back to add, so an x op means a broken decode path
    op_known: assert final (!$isunknown(req.op))
        else $error("alu op is unknown");

endmodule

`default_nettype wire

// ==== hw/exu_branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_branch_resolve import exu_pkg::*; (
    input  logic   valid,
    input  logic   ready_ex_mem,
    input  id_ex_t id_q,
    input  xlen_t  rs1_val,
    input  xlen_t  rs2_val,
    input  xlen_t  alu_result,
    output logic   pc_update,
    output xlen_t  dnpc
);

    logic  is_jump;
    logic  is_branch;
    logic  backward;
    logic  eq;
    logic  lt;
    logic  ltu;
    logic  taken;
    xlen_t target;

    assign is_jump   = (id_q.op_class == op_jal) || (id_q.op_class == op_jalr);
    assign is_branch = (id_q.op_class == op_branch);
    // negative offset so fetch predicted taken
    assign backward  = id_q.imm[xlen-1];

    // alu_result holds rs1 - rs2 for branches
    assign eq  = (alu_result == '0);
    assign lt  = (rs1_val[xlen-1] ^ rs2_val[xlen-1]) ? rs1_val[xlen-1] : alu_result[xlen-1];
    assign ltu = (rs1_val[xlen-1] ^ rs2_val[xlen-1]) ? rs2_val[xlen-1] : alu_result[xlen-1];

    always_comb begin
        case (id_q.funct3)
            3'b000:  taken = eq;
            3'b001:  taken = !eq;
            3'b100:  taken = lt;
            3'b101:  taken = !lt;
            3'b110:  taken = ltu;
            3'b111:  taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    // jalr bit 0 left as computed
    assign target = (id_q.op_class == op_jalr) ? rs1_val + id_q.imm : id_q.pc + id_q.imm;

    // redirect only when the static guess was wrong
    assign pc_update = valid && ready_ex_mem &&
                       (is_jump || (is_branch && (taken ^ backward)));

    assign dnpc = (is_jump || (is_branch && !backward)) ? target
                                                       : id_q.pc + xlen_t'(inst_bytes);

endmodule

`default_nettype wire

// ==== hw/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    valid_id_ex,
    input  id_ex_t  id_ex,
    output logic    ready_id_ex,
    input  fwd_t    fwd_mem,
    input  fwd_t    fwd_wb,
    input  logic    branch_flush,
    output logic    valid_ex_mem,
    input  logic    ready_ex_mem,
    output ex_mem_t ex_mem,
    output logic    pc_update,
    output xlen_t   dnpc
);

    logic     valid;
    id_ex_t   id_q;
    alu_req_t req;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    xlen_t    alu_result;

    // single-cycle stage, mem back-pressure passes straight up
    assign ready_id_ex = ready_ex_mem;

    exu_id_ex_reg u_id_ex_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (valid_id_ex),
        .id_in    (id_ex),
        .advance  (ready_id_ex),
        .flush    (branch_flush),
        .valid    (valid),
        .id_q     (id_q)
    );

    exu_operand_stage u_operand_stage (
        .id_q    (id_q),
        .fwd_mem (fwd_mem),
        .fwd_wb  (fwd_wb),
        .req     (req),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    exu_alu u_alu (
        .req    (req),
        .result (alu_result)
    );

    exu_branch_resolve u_branch_resolve (
        .valid        (valid),
        .ready_ex_mem (ready_ex_mem),
        .id_q         (id_q),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .alu_result   (alu_result),
        .pc_update    (pc_update),
        .dnpc         (dnpc)
    );

    assign valid_ex_mem = valid;

    // forwarded rs2 is the store data
    assign ex_mem.pc         = id_q.pc;
    assign ex_mem.op_class   = id_q.op_class;
    assign ex_mem.funct3     = id_q.funct3;
    assign ex_mem.rd         = id_q.rd;
    assign ex_mem.alu_result = alu_result;
    assign ex_mem.store_data = rs2_val;

endmodule

`default_nettype wire

// ==== testbench/tb_exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exu import exu_pkg::*; ();

    logic    clk = 1'b0;
    logic    rst_n;
    logic    valid_id_ex;
    id_ex_t  id_ex;
    logic    ready_id_ex;
    fwd_t    fwd_mem;
    fwd_t    fwd_wb;
    logic    branch_flush;
    logic    valid_ex_mem;
    logic    ready_ex_mem;
    ex_mem_t ex_mem;
    logic    pc_update;
    xlen_t   dnpc;

    // model copy of the id/ex register
    logic    m_valid;
    id_ex_t  m_id;
    logic    started;
    // forwarding meant for the instruction sent last
    fwd_t    next_mem;
    fwd_t    next_wb;
    int      check_errors = 0;
    int      timeouts = 0;

    xlen_t   e_rs1;
    xlen_t   e_rs2;
    xlen_t   e_result;
    xlen_t   e_dnpc;
    logic    e_taken;
    logic    e_pc_update;

    op_class_e  misc_class [6] = '{op_lui, op_auipc, op_jal, op_jalr, op_load, op_store};
    logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    always #10 clk = ~clk;

    exu_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_id_ex  (valid_id_ex),
        .id_ex        (id_ex),
        .ready_id_ex  (ready_id_ex),
        .fwd_mem      (fwd_mem),
        .fwd_wb       (fwd_wb),
        .branch_flush (branch_flush),
        .valid_ex_mem (valid_ex_mem),
        .ready_ex_mem (ready_ex_mem),
        .ex_mem       (ex_mem),
        .pc_update    (pc_update),
        .dnpc         (dnpc)
    );

    // flush first, then capture only while mem is ready
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (branch_flush) begin
            m_valid <= 1'b0;
        end else if (ready_ex_mem) begin
            m_valid <= valid_id_ex;
            m_id    <= id_ex;
        end
    end

    // newest writer wins and x0 is never replaced
    function automatic xlen_t fwd_pick(input reg_addr_t rs, input xlen_t rf, input fwd_t mem,
                                       input fwd_t wb);
        if (rs != 5'd0 && mem.wen && mem.rd == rs) begin
            return mem.data;
        end
        if (rs != 5'd0 && wb.wen && wb.rd == rs) begin
            return wb.data;
        end
        return rf;
    endfunction

    // rv64i integer op by funct3
    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic sub, input logic arith,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: return (a < b) ? 64'd1 : 64'd0;
            3'd4: return a ^ b;
            3'd5: return arith ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    always_comb begin
        e_rs1 = fwd_pick(m_id.rs1, m_id.src_a, fwd_mem, fwd_wb);
        e_rs2 = m_id.src_b;
        if (m_id.op_class inside {op_branch, op_store, op_reg}) begin
            e_rs2 = fwd_pick(m_id.rs2, m_id.src_b, fwd_mem, fwd_wb);
        end
        case (m_id.op_class)
            op_lui:          e_result = m_id.imm;
            op_auipc:        e_result = m_id.pc + m_id.imm;
            op_jal, op_jalr: e_result = m_id.pc + 64'd4;
            op_branch:       e_result = e_rs1 - e_rs2;
            // immediate forms have no subtract
            op_imm:  e_result = alu_ref(m_id.funct3, 1'b0, m_id.alt, e_rs1, m_id.imm);
            op_reg:  e_result = alu_ref(m_id.funct3, m_id.alt, m_id.alt, e_rs1, e_rs2);
            default: e_result = e_rs1 + m_id.imm;
        endcase
        case (m_id.funct3)
            3'd0:    e_taken = (e_rs1 == e_rs2);
            3'd1:    e_taken = (e_rs1 != e_rs2);
            3'd4:    e_taken = ($signed(e_rs1) < $signed(e_rs2));
            3'd5:    e_taken = ($signed(e_rs1) >= $signed(e_rs2));
            3'd6:    e_taken = (e_rs1 < e_rs2);
            3'd7:    e_taken = (e_rs1 >= e_rs2);
            default: e_taken = 1'b0;
        endcase
        // backward predicted taken and forward predicted not taken
        e_pc_update = m_valid && ready_ex_mem &&
                      ((m_id.op_class inside {op_jal, op_jalr}) ||
                       (m_id.op_class == op_branch && (e_taken != m_id.imm[63])));
        if (m_id.op_class == op_jalr) begin
            e_dnpc = e_rs1 + m_id.imm;
        end else if (m_id.op_class == op_jal || (m_id.op_class == op_branch && !m_id.imm[63])) begin
            e_dnpc = m_id.pc + m_id.imm;
        end else begin
            e_dnpc = m_id.pc + 64'd4;
        end
    end

    task automatic report_mismatch(input string name, input logic [255:0] exp,
                                   input logic [255:0] got);
        check_errors++;
        $display("FAIL %0t %s exp=%0h got=%0h", $time, name, exp, got);
    endtask

    idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (!valid_ex_mem && !pc_update))
        else report_mismatch("valid_ex_mem/pc_update", 0, {$sampled(valid_ex_mem), $sampled(pc_update)});
    valid_match: assert property (@(posedge clk) disable iff (!rst_n) valid_ex_mem == m_valid)
        else report_mismatch("valid_ex_mem", $sampled(m_valid), $sampled(valid_ex_mem));
    redirect_match: assert property (@(posedge clk) disable iff (!rst_n) pc_update == e_pc_update)
        else report_mismatch("pc_update", $sampled(e_pc_update), $sampled(pc_update));
    result_match: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid |-> ex_mem.alu_result == e_result)
        else report_mismatch("ex_mem.alu_result", $sampled(e_result), $sampled(ex_mem.alu_result));
    store_match: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid |-> ex_mem.store_data == e_rs2)
        else report_mismatch("ex_mem.store_data", $sampled(e_rs2), $sampled(ex_mem.store_data));
    rd_match: assert property (@(posedge clk) disable iff (!rst_n) m_valid |-> ex_mem.rd == m_id.rd)
        else report_mismatch("ex_mem.rd", $sampled(m_id.rd), $sampled(ex_mem.rd));
    dnpc_match: assert property (@(posedge clk) disable iff (!rst_n) m_valid |-> dnpc == e_dnpc)
        else report_mismatch("dnpc", $sampled(e_dnpc), $sampled(dnpc));
    // pc, class and funct3 pass straight through
    fields_match: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid |-> {ex_mem.pc, ex_mem.op_class, ex_mem.funct3} ==
                    {m_id.pc, m_id.op_class, m_id.funct3})
        else report_mismatch("ex_mem.pc/op_class/funct3",
                             $sampled({m_id.pc, m_id.op_class, m_id.funct3}),
                             $sampled({ex_mem.pc, ex_mem.op_class, ex_mem.funct3}));
    // stage never stalls on its own
    ready_match: assert property (@(posedge clk) disable iff (!rst_n)
        ready_id_ex == ready_ex_mem)
        else report_mismatch("ready_id_ex", $sampled(ready_ex_mem), $sampled(ready_id_ex));
    no_redirect_held: assert property (@(posedge clk) disable iff (!rst_n)
        !ready_ex_mem |-> !pc_update)
        else report_mismatch("pc_update", 0, $sampled(pc_update));
    flush_drop: assert property (@(posedge clk) disable iff (!rst_n) branch_flush |=> !valid_ex_mem)
        else report_mismatch("valid_ex_mem", 0, $sampled(valid_ex_mem));

    function automatic xlen_t rand_x();
        return {$urandom, $urandom};
    endfunction

    function automatic fwd_t make_fwd(input logic wen, input reg_addr_t rd, input xlen_t data);
        fwd_t f;
        f.wen  = wen;
        f.rd   = rd;
        f.data = data;
        return f;
    endfunction

    // small register range so matches happen often
    function automatic fwd_t rand_fwd();
        return make_fwd(1'($urandom), 5'($urandom % 4), rand_x());
    endfunction

    function automatic id_ex_t build_inst(input op_class_e cls, input logic [2:0] f3,
                                          input logic alt, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input xlen_t a, input xlen_t b,
                                          input xlen_t imm);
        id_ex_t i;
        i.pc       = {32'h0, $urandom} & ~64'h3;
        i.op_class = cls;
        i.funct3   = f3;
        i.alt      = alt;
        i.rd       = 5'($urandom);
        i.rs1      = rs1;
        i.rs2      = rs2;
        i.src_a    = a;
        i.src_b    = b;
        i.imm      = imm;
        return i;
    endfunction

    // fwd driven now belongs to the previous instruction held in the register
    task automatic send(input id_ex_t inst, input fwd_t fm, input fwd_t fw);
        int waited;
        @(negedge clk);
        valid_id_ex = 1'b1;
        id_ex       = inst;
        fwd_mem     = next_mem;
        fwd_wb      = next_wb;
        next_mem    = fm;
        next_wb     = fw;
        started     = 1'b1;
        waited      = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!ready_id_ex && waited < 20);
        if (!ready_id_ex) begin
            timeouts++;
            $display("timeout: the stage did not accept an instruction");
        end
    endtask

    task automatic idle();
        @(negedge clk);
        valid_id_ex = 1'b0;
        fwd_mem     = next_mem;
        fwd_wb      = next_wb;
        next_mem    = '0;
        next_wb     = '0;
    endtask

    initial begin
        id_ex_t inst;
        xlen_t  a;
        xlen_t  imm;
        void'($urandom(32'hccf81670));
        rst_n        = 1'b0;
        valid_id_ex  = 1'b0;
        id_ex        = '0;
        fwd_mem      = '0;
        fwd_wb       = '0;
        branch_flush = 1'b0;
        ready_ex_mem = 1'b1;
        started      = 1'b0;
        next_mem     = '0;
        next_wb      = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        // funct3 x alt reaches all ten alu ops
        for (int i = 0; i < 60; i++) begin
            inst = build_inst(($urandom % 2) ? op_reg : op_imm, 3'($urandom), 1'($urandom),
                              5'($urandom % 4), 5'($urandom % 4), rand_x(), rand_x(), rand_x());
            send(inst, rand_fwd(), rand_fwd());
        end
        for (int i = 0; i < 24; i++) begin
            inst = build_inst(misc_class[i % 6], 3'($urandom), 1'b0, 5'($urandom % 4),
                              5'($urandom % 4), rand_x(), rand_x(), rand_x());
            send(inst, rand_fwd(), rand_fwd());
        end

        // mem and wb both hit so mem wins
        inst = build_inst(op_reg, 3'd0, 1'b0, 5'd3, 5'd3, rand_x(), rand_x(), rand_x());
        send(inst, make_fwd(1'b1, 5'd3, rand_x()), make_fwd(1'b1, 5'd3, rand_x()));
        // wb only on rs2
        inst = build_inst(op_reg, 3'd4, 1'b0, 5'd3, 5'd4, rand_x(), rand_x(), rand_x());
        send(inst, make_fwd(1'b1, 5'd5, rand_x()), make_fwd(1'b1, 5'd4, rand_x()));
        // x0 is never forwarded
        inst = build_inst(op_reg, 3'd6, 1'b0, 5'd0, 5'd0, rand_x(), rand_x(), rand_x());
        send(inst, make_fwd(1'b1, 5'd0, rand_x()), make_fwd(1'b1, 5'd0, rand_x()));
        // write enable low
        inst = build_inst(op_reg, 3'd0, 1'b1, 5'd3, 5'd4, rand_x(), rand_x(), rand_x());
        send(inst, make_fwd(1'b0, 5'd3, rand_x()), make_fwd(1'b0, 5'd4, rand_x()));
        // op_imm does not read rs2
        inst = build_inst(op_imm, 3'd0, 1'b0, 5'd2, 5'd6, rand_x(), rand_x(), rand_x());
        send(inst, make_fwd(1'b1, 5'd6, rand_x()), '0);
        inst = build_inst(op_store, 3'd3, 1'b0, 5'd2, 5'd6, rand_x(), rand_x(), rand_x());
        send(inst, '0, make_fwd(1'b1, 5'd6, rand_x()));

        // equal, random and sign-flipped operand pairs in both directions
        for (int f = 0; f < 6; f++) begin
            for (int k = 0; k < 6; k++) begin
                a   = rand_x();
                imm = xlen_t'(8 * (1 + $urandom % 64));
                if (k % 2 == 1) begin
                    imm = -imm;
                end
                inst = build_inst(op_branch, br_f3[f], 1'b0, 5'd1, 5'd2, a,
                                  (k < 2) ? a : (k < 4) ? rand_x() : a ^ {1'b1, 63'h0}, imm);
                send(inst, rand_fwd(), rand_fwd());
            end
        end

        // forward taken branch held under back-pressure
        a    = rand_x();
        inst = build_inst(op_branch, 3'd0, 1'b0, 5'd1, 5'd2, a, a, 64'd16);
        send(inst, '0, '0);
        @(negedge clk);
        ready_ex_mem = 1'b0;
        valid_id_ex  = 1'b1;
        id_ex        = build_inst(op_reg, 3'd0, 1'b0, 5'd1, 5'd2, rand_x(), rand_x(), rand_x());
        fwd_mem      = '0;
        fwd_wb       = '0;
        repeat (4) @(negedge clk);
        branch_flush = 1'b1;
        @(negedge clk);
        branch_flush = 1'b0;
        valid_id_ex  = 1'b0;
        ready_ex_mem = 1'b1;
        for (int i = 0; i < 8; i++) begin
            inst = build_inst(op_reg, 3'($urandom), 1'($urandom), 5'($urandom % 4),
                              5'($urandom % 4), rand_x(), rand_x(), rand_x());
            send(inst, rand_fwd(), rand_fwd());
        end
        idle();
        repeat (3) @(negedge clk);

        $display("errors: checks %0d, timeouts %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hw/exu_pkg.sv
hw/exu_id_ex_reg.sv
hw/exu_operand_stage.sv
hw/exu_alu.sv
hw/exu_branch_resolve.sv
hw/exu_top.sv
testbench/tb_exu.sv

// ==== Bender.yml ====
package:
  name: exu

sources:
  - hw/exu_pkg.sv
  - hw/exu_id_ex_reg.sv
  - hw/exu_operand_stage.sv
  - hw/exu_alu.sv
  - hw/exu_branch_resolve.sv
  - hw/exu_top.sv
  - target: test
    files:
      - testbench/tb_exu.sv
